// ==== rx_link_top.f ====
verilog/qec_link_pkg.sv
verilog/rx_frame_aligner.sv
verilog/rx_frame_monitor.sv
verilog/rx_link_top.sv
sim/tb_rx_link.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ns -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ns
TOP        = tb_rx_link
FILELIST   = rx_link_top.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_rx_link.sv ====
// Directed tests at one word per clock; payload is expected from the first frame sent after lock
`timescale 1ns/1ns
`default_nettype none

module tb_rx_link;
   import qec_link_pkg::*;

   localparam int ERR_CNT_W   = 16;
   localparam int CHECK_FAWS  = 7;
   localparam int LOCK_FRAMES = CHECK_FAWS + 3;  // Lock budget in frames
   localparam int BLOCKS      = (FRAME_LEN - 1) / CRC_BLOCK_LEN;

   logic                 clk_i = 1'b0;
   logic                 rst_n_i;
   logic                 enable_i;
   word_t                rx_data_i;
   logic                 locked_o;
   word_t                payload_o;
   logic                 payload_valid_o;
   logic                 faw_error_o;
   logic                 crc_error_o;
   logic [ERR_CNT_W-1:0] faw_err_count_o;
   logic [ERR_CNT_W-1:0] crc_err_count_o;

   word_t exp_q[$];              // Payload words still due at the output
   word_t exp_word;
   logic  expect_payload = 1'b0; // Data words are queued only once locked
   int    mismatches     = 0;
   int    other_errors   = 0;
   int    words_checked  = 0;
   int    crc_pulses     = 0;    // crc_error_o cycles seen
   int    faw_pulses     = 0;

   rx_link_top #(
      .ERR_CNT_W       (ERR_CNT_W),
      .CHECK_FAWS      (CHECK_FAWS)
   ) rx_link_top_i (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .enable_i        (enable_i),
      .rx_data_i       (rx_data_i),
      .locked_o        (locked_o),
      .payload_o       (payload_o),
      .payload_valid_o (payload_valid_o),
      .faw_error_o     (faw_error_o),
      .crc_error_o     (crc_error_o),
      .faw_err_count_o (faw_err_count_o),
      .crc_err_count_o (crc_err_count_o)
   );

   always #2 clk_i = ~clk_i;  // 4 ns period

   //--------------------------------------------------
   // Compare tasks and run control
   //--------------------------------------------------
   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input logic [ERR_CNT_W-1:0] got,
                              input logic [ERR_CNT_W-1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic finish_run();
      $display("Summary: %0d mismatches, %0d other errors, %0d payload words checked",
               mismatches, other_errors, words_checked);
      if (mismatches + other_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   endtask

   // Every wait is bounded, so the run still reaches the closing report
   task automatic report_timeout(input string what);
      other_errors++;
      $display("ERROR: timeout, %s", what);
   endtask

   // Output side, sampled mid-cycle where everything is settled
   always @(negedge clk_i) begin
      if (rst_n_i) begin
         if (payload_valid_o) begin
            if (exp_q.size() == 0) begin
               other_errors++;
               $display("ERROR: payload_valid_o high when no payload word was due");
            end else begin
               exp_word = exp_q.pop_front();
               check_word("payload_o", payload_o, exp_word);
               words_checked++;
            end
         end
         if (crc_error_o) crc_pulses++;
         if (faw_error_o) faw_pulses++;
      end
   end

   //--------------------------------------------------
   // Stimulus
   //--------------------------------------------------
   task automatic drive_word(input word_t w);
      @(posedge clk_i);
      #1;
      rx_data_i = w;
   endtask

   task automatic send_random(input int n);
      repeat (n) drive_word({$urandom(), $urandom()});
   endtask

   // FAW, then nine blocks of six data words and a CRC word
   task automatic send_frame(input logic bad_faw, input int bad_block);
      word_t w;
      crc_t  crc;
      drive_word(bad_faw ? ~FAW_WORD : FAW_WORD);
      for (int k = 0; k < BLOCKS; k++) begin
         crc = CRC_INIT;
         for (int j = 1; j < CRC_BLOCK_LEN; j++) begin
            w   = {$urandom(), $urandom()};
            crc = crc32_step(crc, w);
            if (expect_payload) exp_q.push_back(w);
            drive_word(w);
         end
         if (k == bad_block) crc = crc ^ 32'h0000_0100;  // Single bit flip
         drive_word({32'h0, crc});
      end
   endtask

   task automatic acquire_lock();
      int n;
      n = 0;
      while (!locked_o && n < LOCK_FRAMES) begin
         send_frame(1'b0, -1);
         n++;
      end
      if (!locked_o) report_timeout("locked_o did not rise within the lock budget");
      expect_payload = 1'b1;  // Next FAW is the first enabled boundary
   endtask

   // Drop enable on the FAW slot that follows a frame
   task automatic stop_link();
      int n;
      expect_payload = 1'b0;
      @(posedge clk_i);
      #1;
      enable_i  = 1'b0;
      rx_data_i = FAW_WORD;
      n = 0;
      while (locked_o && n < 8) begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (locked_o) report_timeout("locked_o stayed high after enable_i fell");
      n = 0;
      while (exp_q.size() != 0 && n < 8) begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (exp_q.size() != 0) report_timeout("payload words never came out");
   endtask

   //--------------------------------------------------
   // Tests
   //--------------------------------------------------
   task automatic test_idle();
      repeat (4) @(posedge clk_i);
      #1;
      check_bit("locked_o", locked_o, 1'b0);
      check_bit("payload_valid_o", payload_valid_o, 1'b0);
      check_bit("faw_error_o", faw_error_o, 1'b0);
      check_bit("crc_error_o", crc_error_o, 1'b0);
      check_count("faw_err_count_o", faw_err_count_o, '0);
      check_count("crc_err_count_o", crc_err_count_o, '0);
   endtask

   task automatic test_clean_lock();
      enable_i = 1'b1;
      send_random(37);  // Frame start lands off any fixed offset
      acquire_lock();
      repeat (3) send_frame(1'b0, -1);
      check_bit("locked_o", locked_o, 1'b1);
      check_count("faw_err_count_o", faw_err_count_o, '0);
      check_count("crc_err_count_o", crc_err_count_o, '0);
   endtask

   task automatic test_crc_errors();
      send_frame(1'b0, 0);
      send_frame(1'b0, 4);
      send_frame(1'b0, BLOCKS - 1);  // Block that ends the frame
      send_frame(1'b0, -1);
      check_count("crc_err_count_o", crc_err_count_o, ERR_CNT_W'(3));
      check_count("crc_error_o pulses", ERR_CNT_W'(crc_pulses), ERR_CNT_W'(3));
      check_count("faw_err_count_o", faw_err_count_o, '0);
   endtask

   task automatic test_faw_errors();
      send_frame(1'b1, -1);
      send_frame(1'b0, -1);
      send_frame(1'b1, -1);
      send_frame(1'b0, -1);
      check_count("faw_err_count_o", faw_err_count_o, ERR_CNT_W'(2));
      check_count("faw_error_o pulses", ERR_CNT_W'(faw_pulses), ERR_CNT_W'(2));
      check_bit("locked_o", locked_o, 1'b1);  // No relock on FAW errors
   endtask

   task automatic test_enable_drop();
      stop_link();
      repeat (16) begin
         @(posedge clk_i);
         #1;
         check_bit("payload_valid_o", payload_valid_o, 1'b0);
      end
      enable_i = 1'b1;
      send_random(37);
      // Every other FAW is bad, the good run never reaches CHECK_FAWS
      for (int f = 0; f < 20; f++) begin
         send_frame((f % 2) == 1, -1);
         check_bit("locked_o", locked_o, 1'b0);
      end
      acquire_lock();
      repeat (3) send_frame(1'b0, -1);
      check_bit("locked_o", locked_o, 1'b1);
      check_count("crc_err_count_o", crc_err_count_o, ERR_CNT_W'(3));  // Held across enable
      check_count("faw_err_count_o", faw_err_count_o, ERR_CNT_W'(2));
   endtask

   initial begin
      void'($urandom(33));
      rst_n_i   = 1'b0;
      enable_i  = 1'b0;
      rx_data_i = '0;
      repeat (8) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      test_idle();
      test_clean_lock();
      test_crc_errors();
      test_faw_errors();
      test_enable_drop();
      stop_link();  // Flush the last payload words
      finish_run();
   end

endmodule

`default_nettype wire

// ==== verilog/rx_link_top.sv ====
// One word per clock and no back-pressure; lock is only released by dropping enable_i
`timescale 1ns/1ns
`default_nettype none

module rx_link_top #(
   parameter int ERR_CNT_W  = 16,  // Monitor error counter width
   parameter int CHECK_FAWS = 7    // Good FAWs in a row before lock
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 enable_i,
   input  qec_link_pkg::word_t  rx_data_i,
   output logic                 locked_o,
   output qec_link_pkg::word_t  payload_o,
   output logic                 payload_valid_o,
   output logic                 faw_error_o,
   output logic                 crc_error_o,
   output logic [ERR_CNT_W-1:0] faw_err_count_o,
   output logic [ERR_CNT_W-1:0] crc_err_count_o
);
   import qec_link_pkg::*;

   //--------------------------------------------------
   // Aligner to monitor
   //--------------------------------------------------
   word_t aligned_data;  // Strobes line up with this word
   logic  locked;
   logic  faw_boundary;
   logic  crc_boundary;

   assign locked_o = locked;

   rx_frame_aligner #(
      .CHECK_FAWS     (CHECK_FAWS)
   ) rx_frame_aligner_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .enable_i       (enable_i),
      .tdata_i        (rx_data_i),
      .tdata_o        (aligned_data),
      .locked_o       (locked),
      .faw_boundary_o (faw_boundary),
      .crc_boundary_o (crc_boundary)
   );

   rx_frame_monitor #(
      .ERR_CNT_W       (ERR_CNT_W)
   ) rx_frame_monitor_i (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .tdata_i         (aligned_data),
      .locked_i        (locked),
      .faw_boundary_i  (faw_boundary),
      .crc_boundary_i  (crc_boundary),
      .payload_o       (payload_o),
      .payload_valid_o (payload_valid_o),
      .faw_error_o     (faw_error_o),
      .crc_error_o     (crc_error_o),
      .faw_err_count_o (faw_err_count_o),
      .crc_err_count_o (crc_err_count_o)
   );

endmodule

`default_nettype wire

// ==== verilog/rx_frame_monitor.sv ====
// Checks only after lock; payload starts at word 1 of the first enabled frame, counters saturate
`timescale 1ns/1ns
`default_nettype none

module rx_frame_monitor #(
   parameter int ERR_CNT_W = 16  // Error counter width
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  qec_link_pkg::word_t  tdata_i,          // Aligned word stream
   input  logic                 locked_i,
   input  logic                 faw_boundary_i,   // Current word is the FAW
   input  logic                 crc_boundary_i,   // Current word is a CRC word
   output qec_link_pkg::word_t  payload_o,
   output logic                 payload_valid_o,  // High for data words only
   output logic                 faw_error_o,      // One-cycle pulse
   output logic                 crc_error_o,      // One-cycle pulse
   output logic [ERR_CNT_W-1:0] faw_err_count_o,
   output logic [ERR_CNT_W-1:0] crc_err_count_o
);
   import qec_link_pkg::*;

   logic frame_run;  // Set at the first enabled FAW boundary
   logic data_word;  // Current word is payload
   crc_t crc_q;      // Running CRC of the current block
   logic faw_bad;
   logic crc_bad;

   // Counter step, held at all ones
   function automatic logic [ERR_CNT_W-1:0] sat_inc(input logic [ERR_CNT_W-1:0] cnt,
                                                     input logic hit);
      if (hit && !(&cnt)) begin
         return cnt + ERR_CNT_W'(1);
      end
      return cnt;
   endfunction

   //--------------------------------------------------
   // Word classification
   //--------------------------------------------------
   assign data_word = locked_i && frame_run && !faw_boundary_i && !crc_boundary_i;

   assign faw_bad = faw_boundary_i && !is_faw(tdata_i);
   // Low half holds the CRC, high half must be zero
   assign crc_bad = crc_boundary_i &&
                    ((tdata_i[31:0] != crc_q) || (tdata_i[WORD_W-1:32] != '0));

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         frame_run <= 1'b0;
      end else if (!locked_i) begin
         frame_run <= 1'b0;  // Lost enable upstream, wait for the next FAW
      end else if (faw_boundary_i) begin
         frame_run <= 1'b1;
      end
   end

   //--------------------------------------------------
   // Running CRC
   //--------------------------------------------------
   // Seeded on both strobes so each block starts clean
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         crc_q <= CRC_INIT;
      end else if (faw_boundary_i || crc_boundary_i) begin
         crc_q <= CRC_INIT;
      end else begin
         crc_q <= crc32_step(crc_q, tdata_i);
      end
   end

   //--------------------------------------------------
   // Registered outputs
   //--------------------------------------------------
   always_ff @(posedge clk_i) begin
      payload_o <= tdata_i;  // Qualified by payload_valid_o
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         payload_valid_o <= 1'b0;
         faw_error_o     <= 1'b0;
         crc_error_o     <= 1'b0;
      end else begin
         payload_valid_o <= data_word;
         faw_error_o     <= faw_bad;
         crc_error_o     <= crc_bad;
      end
   end

   // Kept across enable changes, cleared by reset only
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         faw_err_count_o <= '0;
         crc_err_count_o <= '0;
      end else begin
         faw_err_count_o <= sat_inc(faw_err_count_o, faw_bad);
         crc_err_count_o <= sat_inc(crc_err_count_o, crc_bad);
      end
   end

   a_faw_cnt_mono: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rst_n_i |=> faw_err_count_o >= $past(faw_err_count_o))
      else $error("faw_err_count_o decreased");

   a_crc_cnt_mono: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rst_n_i |=> crc_err_count_o >= $past(crc_err_count_o))
      else $error("crc_err_count_o decreased");

endmodule

`default_nettype wire

// ==== verilog/rx_frame_aligner.sv ====
// Holds lock until enable_i falls and never re-checks the FAW once locked; data passes through
`timescale 1ns/1ns
`default_nettype none

module rx_frame_aligner #(
   parameter int CHECK_FAWS = 7  // Good FAWs in a row needed for lock
) (
   input  logic                clk_i,
   input  logic                rst_n_i,         // Synchronous, active low
   input  logic                enable_i,        // Level, low forces DISABLED
   input  qec_link_pkg::word_t tdata_i,         // Raw received words
   output qec_link_pkg::word_t tdata_o,         // Same words, strobes line up with these
   output logic                locked_o,        // Frame alignment held
   output logic                faw_boundary_o,  // Marks the FAW word once enabled
   output logic                crc_boundary_o   // Marks each CRC word once enabled
);
   import qec_link_pkg::*;

   localparam int POS_W = $clog2(FRAME_LEN);         // Frame position width
   localparam int CRC_W = $clog2(CRC_BLOCK_LEN);     // Block position width
   localparam int CHK_W = $clog2(CHECK_FAWS + 1);    // Good FAW count width

   align_state_t state, state_nxt;

   logic             faw_detected;      // FAW on the current input word
   logic             faw_detected_q;    // Registered copy for the ALIGN search
   logic             faw_realign;       // Reload frame position
   logic             faw_align_done;    // Reload has taken effect

   logic [POS_W-1:0] frame_pos;         // Position inside the 64-word frame
   logic             faw_boundary;      // Raw FAW strobe, runs before lock
   logic [CRC_W-1:0] crc_pos;           // Position inside the 7-word block
   logic             crc_boundary;      // Raw CRC strobe

   logic [CHK_W-1:0] good_faw_cnt;      // Consecutive good FAWs in CHECK
   logic             check_done;
   logic             check_failed;

   logic             locked;
   logic             faw_boundary_en;
   logic             crc_boundary_en;

   assign tdata_o        = tdata_i;                          // No added latency
   assign locked_o       = locked;
   assign faw_boundary_o = faw_boundary & faw_boundary_en;   // Gated strobes
   assign crc_boundary_o = crc_boundary & crc_boundary_en;

   assign faw_detected = enable_i && is_faw(tdata_i);

   //--------------------------------------------------
   // State machine
   //--------------------------------------------------
   always_comb begin
      unique case (state)
         RESET:              state_nxt = DISABLED;
         DISABLED:           state_nxt = ALIGN;  // Only reached with enable high
         ALIGN:              state_nxt = faw_align_done ? CHECK : ALIGN;
         CHECK: begin
            if (check_failed) begin
               state_nxt = ALIGN;   // Bad FAW, start the hunt again
            end else if (check_done) begin
               state_nxt = LOCKED;
            end else begin
               state_nxt = CHECK;
            end
         end
         LOCKED:             state_nxt = FAW_BOUNDARY_START;
         FAW_BOUNDARY_START: state_nxt = faw_boundary ? CRC_BOUNDARY_START : FAW_BOUNDARY_START;
         CRC_BOUNDARY_START: state_nxt = OPERATIONAL;
         OPERATIONAL:        state_nxt = OPERATIONAL;  // Until enable falls
         default:            state_nxt = RESET;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state <= RESET;
      end else if (!enable_i) begin
         state <= DISABLED;  // Enable overrides everything
      end else begin
         state <= state_nxt;
      end
   end

   //--------------------------------------------------
   // FAW search and frame position
   //--------------------------------------------------
   // FAW at cycle t -> detected_q at t+1 -> realign at t+2 -> pos 2 at t+3
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         faw_detected_q <= 1'b0;
         faw_realign    <= 1'b0;
         faw_align_done <= 1'b0;
      end else begin
         faw_detected_q <= faw_detected;
         faw_realign    <= state[2] && faw_detected_q;  // ALIGN bit
         faw_align_done <= faw_realign;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         frame_pos    <= '0;
         faw_boundary <= 1'b0;
      end else begin
         frame_pos    <= faw_realign ? POS_W'(2) : frame_pos + POS_W'(1);
         // Registered compare so the strobe lands on the FAW word itself
         faw_boundary <= (frame_pos == POS_W'(FRAME_LEN - 2));
      end
   end

   // Block position restarts on either strobe, so 9 blocks fit after each FAW
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         crc_pos      <= '0;
         crc_boundary <= 1'b0;
      end else begin
         crc_pos      <= (faw_boundary || crc_boundary) ? '0 : crc_pos + CRC_W'(1);
         crc_boundary <= (crc_pos == CRC_W'(CRC_BLOCK_LEN - 2));
      end
   end

   //--------------------------------------------------
   // Confirmation in CHECK
   //--------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !enable_i) begin
         good_faw_cnt <= '0;
         check_done   <= 1'b0;
         check_failed <= 1'b0;
      end else begin
         check_failed <= state[3] && faw_boundary && !faw_detected;
         if (state[3] && faw_boundary) begin
            good_faw_cnt <= faw_detected ? good_faw_cnt + CHK_W'(1) : '0;
         end
         if (good_faw_cnt == CHK_W'(CHECK_FAWS)) begin
            check_done <= 1'b1;  // Sticky until enable drops
         end
      end
   end

   //--------------------------------------------------
   // Lock and strobe enables
   //--------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !enable_i) begin
         locked          <= 1'b0;
         faw_boundary_en <= 1'b0;
         crc_boundary_en <= 1'b0;
      end else begin
         if (state[4]) locked <= 1'b1;           // LOCKED
         if (state[5]) faw_boundary_en <= 1'b1;  // FAW_BOUNDARY_START
         if (state[6]) crc_boundary_en <= 1'b1;  // CRC_BOUNDARY_START
      end
   end

   // Block checks in the monitor rely on these three properties
   a_crc_needs_lock: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      crc_boundary_o |-> locked_o)
      else $error("crc_boundary_o high without lock");

   a_strobes_apart: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(faw_boundary_o && crc_boundary_o))
      else $error("FAW and CRC boundaries coincide");

   a_state_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot(state))
      else $error("Aligner state not one-hot");

endmodule

`default_nettype wire

// ==== verilog/qec_link_pkg.sv ====
// Frame format is fixed at 64 words of 64 bits; CRC words carry no final XOR and a zero upper half
`default_nettype none

package qec_link_pkg;

   //--------------------------------------------------
   // Frame format
   //--------------------------------------------------
   localparam int WORD_W        = 64;  // Data word width
   localparam int FRAME_LEN     = 64;  // Words per frame, FAW included
   localparam int CRC_BLOCK_LEN = 7;   // Six data words plus one CRC word

   typedef logic [WORD_W-1:0] word_t;  // Link data word
   typedef logic [31:0]       crc_t;   // CRC-32 value

   // Alignment pattern in word 0 of every frame
   localparam word_t FAW_WORD = 64'hA5C3_96E1_0F1E_2D4B;

   localparam crc_t CRC_INIT = 32'hFFFF_FFFF;  // Seed at start of each block
   localparam crc_t CRC_POLY = 32'hEDB8_8320;  // Reflected IEEE 802.3 polynomial

   //--------------------------------------------------
   // Aligner states
   //--------------------------------------------------
   // One-hot, one bit per state so decode is a single bit test
   typedef enum logic [7:0] {
      RESET              = 8'b0000_0001,  // Out of reset
      DISABLED           = 8'b0000_0010,  // Waiting for enable
      ALIGN              = 8'b0000_0100,  // Hunting for a FAW
      CHECK              = 8'b0000_1000,  // Confirming FAWs at boundaries
      LOCKED             = 8'b0001_0000,  // Alignment confirmed
      FAW_BOUNDARY_START = 8'b0010_0000,  // FAW strobe enabled, waiting first one
      CRC_BOUNDARY_START = 8'b0100_0000,  // First FAW boundary passed
      OPERATIONAL        = 8'b1000_0000   // All strobes running
   } align_state_t;

   //--------------------------------------------------
   // Helper functions
   //--------------------------------------------------

   // Exact match only, no bit error tolerance
   function automatic logic is_faw(input word_t data);
      return (data == FAW_WORD);
   endfunction

   // One word of reflected CRC-32, LSB of the word goes in first
   function automatic crc_t crc32_step(input crc_t crc_in, input word_t data);
      crc_t c;
      c = crc_in;
      for (int i = 0; i < WORD_W; i++) begin
         // Shift right, fold in polynomial when the outgoing bit differs from data
         c = (c >> 1) ^ ((c[0] ^ data[i]) ? CRC_POLY : 32'h0);
      end
      return c;
   endfunction

endpackage

`default_nettype wire
